/* sources.f */
mpf_pkg.sv
mpf_ifs.sv
mpf_fifo_lutram.sv
mpf_afu_buffer.sv
mpf_req_arbiter.sv
mpf_mem_port.sv
mpf_top.sv
tb_mpf_top.sv

/* Makefile */
# Verilator build for the memory request shim

SIM        = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_mpf_top
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_mpf_top.sv */
// Memory shim testbench
`timescale 1ns/10ps
`default_nettype none

module tb_mpf_top;

    localparam int AW = mpf_pkg::MPF_ADDR_W;
    localparam int TW = mpf_pkg::MPF_TAG_W;
    localparam int DW = mpf_pkg::MPF_DATA_W;

    // One outstanding request as the testbench remembers it
    typedef struct packed {
        logic [TW-1:0] tag;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [31:0]   cyc;
    } t_req;

    logic          clk;
    logic          rst;
    logic          rd_valid;
    logic [AW-1:0] rd_addr;
    logic [TW-1:0] rd_tag;
    logic          rd_alm_full;
    logic          wr_valid;
    logic [AW-1:0] wr_addr;
    logic [TW-1:0] wr_tag;
    logic [DW-1:0] wr_data;
    logic          wr_alm_full;
    logic          rd_rsp_valid;
    logic [TW-1:0] rd_rsp_tag;
    logic [DW-1:0] rd_rsp_data;
    logic          wr_ack_valid;
    logic [TW-1:0] wr_ack_tag;

    integer        seed = 41;
    int            value_errs = 0;
    int            order_errs = 0;
    int            timeout_errs = 0;
    int            rd_issued = 0;
    int            wr_issued = 0;
    int            rd_done = 0;
    int            wr_done = 0;
    int            last_rd_lat = 0;
    int            last_wr_lat = 0;
    logic [31:0]   cyc = '0;
    logic [TW-1:0] next_rd_tag = '0;
    logic [TW-1:0] next_wr_tag = '0;

    // Shadow of the DUT memory and the requests still waiting for a response
    logic [DW-1:0] shadow [2**AW];
    t_req          rd_q[$];
    t_req          wr_q[$];

    mpf_top #(
        .N_ENTRIES        (8),
        .THRESHOLD        (4),
        .ENABLE_RD_BYPASS (1)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .rd_valid     (rd_valid),
        .rd_addr      (rd_addr),
        .rd_tag       (rd_tag),
        .rd_alm_full  (rd_alm_full),
        .wr_valid     (wr_valid),
        .wr_addr      (wr_addr),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .wr_alm_full  (wr_alm_full),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_tag   (rd_rsp_tag),
        .rd_rsp_data  (rd_rsp_data),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_tag   (wr_ack_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle number of the most recent rising edge
    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // ==========================================================
    // Reference model
    // ==========================================================

    // Initial memory pattern, different for every address bit
    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] addr);
        return {(DW/AW){addr}} ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    // Write acknowledgements and read responses both come one cycle after the
    // memory access, so the shadow holds exactly the writes taken before this read
    function automatic logic [DW-1:0] ref_read_data(input logic [AW-1:0] addr);
        return shadow[addr];
    endfunction

    // ==========================================================
    // Stimulus and waits
    // ==========================================================

    // One cycle of requests, offered only while that channel's almost-full is low
    task automatic drive_cycle(input logic want_rd, input logic [AW-1:0] ra,
                               input logic want_wr, input logic [AW-1:0] wa,
                               input logic [DW-1:0] wd);
        t_req r;
        @(posedge clk);
        #2;
        rd_valid = want_rd && !rd_alm_full;
        wr_valid = want_wr && !wr_alm_full;
        rd_addr  = ra;
        rd_tag   = next_rd_tag;
        wr_addr  = wa;
        wr_tag   = next_wr_tag;
        wr_data  = wd;
        if (rd_valid)
        begin
            r = '{tag: next_rd_tag, addr: ra, data: '0, cyc: cyc};
            rd_q.push_back(r);
            next_rd_tag = next_rd_tag + 1'b1;
            rd_issued++;
        end
        if (wr_valid)
        begin
            r = '{tag: next_wr_tag, addr: wa, data: wd, cyc: cyc};
            wr_q.push_back(r);
            next_wr_tag = next_wr_tag + 1'b1;
            wr_issued++;
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic wait_responses(input int rd_target, input int wr_target, input int limit);
        int n;
        n = 0;
        while ((rd_done < rd_target || wr_done < wr_target) && n < limit)
        begin
            @(posedge clk);
            n++;
        end
        if (rd_done < rd_target || wr_done < wr_target)
        begin
            $display("Timeout at %0t: %0d of %0d reads and %0d of %0d writes answered",
                     $time, rd_done, rd_target, wr_done, wr_target);
            timeout_errs++;
        end
    endtask

    task automatic wait_rd_alm_low(input int limit);
        int n;
        n = 0;
        while (rd_alm_full && n < limit)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (rd_alm_full)
        begin
            $display("Timeout at %0t: rd_alm_full stayed high while reads drained", $time);
            timeout_errs++;
        end
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0)
        begin
            $display("[FAIL] %0t %s got %b expected 0", $time, name, value);
            value_errs++;
        end
    endtask

    task automatic expect_latency(input string name, input int got, input int want);
        if (got != want)
        begin
            $display("[FAIL] %0t %s latency got %0d expected %0d", $time, name, got, want);
            value_errs++;
        end
    endtask

    // ==========================================================
    // Response comparison
    // ==========================================================

    // Outputs are sampled mid-cycle, well away from both clock edge and input changes
    always @(negedge clk)
    begin : compare
        t_req w;
        t_req r;
        logic [DW-1:0] exp_data;
        if (!rst && wr_ack_valid)
        begin
            if (wr_q.size() == 0)
            begin
                $display("Write acknowledgement at %0t with no write outstanding", $time);
                order_errs++;
            end
            else
            begin
                w = wr_q.pop_front();
                if (wr_ack_tag !== w.tag)
                begin
                    $display("[FAIL] %0t wr_ack_tag got %0h expected %0h",
                             $time, wr_ack_tag, w.tag);
                    value_errs++;
                end
                shadow[w.addr] = w.data;
                last_wr_lat = cyc - w.cyc;
                wr_done++;
            end
        end
        if (!rst && rd_rsp_valid)
        begin
            if (rd_q.size() == 0)
            begin
                $display("Read response at %0t with no read outstanding", $time);
                order_errs++;
            end
            else
            begin
                r = rd_q.pop_front();
                if (rd_rsp_tag !== r.tag)
                begin
                    $display("[FAIL] %0t rd_rsp_tag got %0h expected %0h",
                             $time, rd_rsp_tag, r.tag);
                    value_errs++;
                end
                // Every write accepted strictly before this read must be done by now
                if (wr_q.size() != 0 && wr_q[0].cyc < r.cyc)
                begin
                    $display("Read tag %0h at %0t overtook a write accepted before it",
                             r.tag, $time);
                    order_errs++;
                end
                exp_data = ref_read_data(r.addr);
                if (rd_rsp_data !== exp_data)
                begin
                    $display("[FAIL] %0t rd_rsp_data got %h expected %h",
                             $time, rd_rsp_data, exp_data);
                    value_errs++;
                end
                last_rd_lat = cyc - r.cyc;
                rd_done++;
            end
        end
    end

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial
    begin : main
        int i;
        int rd_mark;
        logic af_seen;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        rst      = 1'b1;
        rd_valid = 1'b0;
        rd_addr  = '0;
        rd_tag   = '0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_tag   = '0;
        wr_data  = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // Quiet outputs after reset with nothing offered
        for (i = 0; i < 10; i++)
        begin
            @(negedge clk);
            expect_low("rd_alm_full", rd_alm_full);
            expect_low("wr_alm_full", wr_alm_full);
            expect_low("rd_rsp_valid", rd_rsp_valid);
            expect_low("wr_ack_valid", wr_ack_valid);
        end

        // Give every word a known value before anything reads it
        for (i = 0; i < 2**AW; i++)
            drive_cycle(1'b0, '0, 1'b1, i[AW-1:0], fill_word(i[AW-1:0]));
        idle_cycle();
        wait_responses(rd_issued, wr_issued, 100);

        // Single requests into an idle design, read bypass then write through the FIFO
        repeat (3) idle_cycle();
        drive_cycle(1'b1, 8'h3c, 1'b0, '0, '0);
        idle_cycle();
        wait_responses(rd_issued, wr_issued, 20);
        expect_latency("rd_rsp_valid", last_rd_lat, 1);
        drive_cycle(1'b0, '0, 1'b1, 8'h3c, 64'h5eed_0bad_f00d_cafe);
        idle_cycle();
        wait_responses(rd_issued, wr_issued, 20);
        expect_latency("wr_ack_valid", last_wr_lat, 2);
        drive_cycle(1'b1, 8'h3c, 1'b0, '0, '0);
        idle_cycle();
        wait_responses(rd_issued, wr_issued, 20);
        expect_latency("rd_rsp_valid", last_rd_lat, 1);

        // Random mix, at most one read and one write per cycle
        for (i = 0; i < 300; i++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            r4 = $random(seed);
            drive_cycle(r1[0], r1[15:8], r1[1], r1[23:16], {r3, r4 ^ r2});
        end
        idle_cycle();
        wait_responses(rd_issued, wr_issued, 400);

        // Write flood with a few reads held behind it
        // The arbiter drains one write per cycle, as fast as writes can arrive,
        // so the write FIFO never gets near its threshold
        rd_mark = rd_done;
        for (i = 0; i < 40; i++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            drive_cycle(i >= 1 && i <= 4, r1[7:0], 1'b1, r1[15:8], {r2, r3});
            expect_low("wr_alm_full", wr_alm_full);
        end
        idle_cycle();
        wait_responses(rd_mark, wr_issued, 50);
        if (rd_done != rd_mark)
        begin
            $display("Held reads returned at %0t before the write flood drained", $time);
            order_errs++;
        end
        wait_responses(rd_issued, wr_issued, 50);

        // Reads pile up behind steady writes until almost-full stops them
        af_seen = 1'b0;
        for (i = 0; i < 30; i++)
        begin
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            drive_cycle(i >= 1, r1[7:0], 1'b1, r1[15:8], {r2, r3});
            if (rd_alm_full)
                af_seen = 1'b1;
        end
        idle_cycle();
        if (!af_seen)
        begin
            $display("rd_alm_full never rose while reads queued behind writes");
            order_errs++;
        end
        wait_rd_alm_low(60);
        wait_responses(rd_issued, wr_issued, 100);

        repeat (4) idle_cycle();
        if (rd_q.size() != 0 || wr_q.size() != 0)
        begin
            $display("%0d reads and %0d writes were never answered", rd_q.size(), wr_q.size());
            order_errs++;
        end

        $display("Errors: %0d value, %0d order, %0d timeout", value_errs, order_errs,
                 timeout_errs);
        if (value_errs + order_errs + timeout_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* mpf_top.sv */
// Memory request shim top level
`timescale 1ns/10ps
`default_nettype none

module mpf_top #(
    parameter int N_ENTRIES        = 8,
    parameter int THRESHOLD        = 4,
    parameter int ENABLE_RD_BYPASS = 1
) (
    input  wire                             clk,
    input  wire                             rst,

    // Channel 0, reads
    input  wire                             rd_valid,
    input  wire  [mpf_pkg::MPF_ADDR_W-1:0]  rd_addr,
    input  wire  [mpf_pkg::MPF_TAG_W-1:0]   rd_tag,
    output logic                            rd_alm_full,

    // Channel 1, writes
    input  wire                             wr_valid,
    input  wire  [mpf_pkg::MPF_ADDR_W-1:0]  wr_addr,
    input  wire  [mpf_pkg::MPF_TAG_W-1:0]   wr_tag,
    input  wire  [mpf_pkg::MPF_DATA_W-1:0]  wr_data,
    output logic                            wr_alm_full,

    // Responses
    output logic                            rd_rsp_valid,
    output logic [mpf_pkg::MPF_TAG_W-1:0]   rd_rsp_tag,
    output logic [mpf_pkg::MPF_DATA_W-1:0]  rd_rsp_data,
    output logic                            wr_ack_valid,
    output logic [mpf_pkg::MPF_TAG_W-1:0]   wr_ack_tag
);

    // Pack the flat request ports into the buffered payload formats
    mpf_pkg::t_rd_hdr rd_hdr;
    mpf_pkg::t_wr_req wr_req;

    assign rd_hdr.addr     = rd_addr;
    assign rd_hdr.tag      = rd_tag;
    assign wr_req.hdr.addr = wr_addr;
    assign wr_req.hdr.tag  = wr_tag;
    assign wr_req.data     = wr_data;

    mpf_tx_if  tx_if ();
    mpf_mem_if mem_if ();

    mpf_afu_buffer #(
        .N_ENTRIES        (N_ENTRIES),
        .THRESHOLD        (THRESHOLD),
        .ENABLE_RD_BYPASS (ENABLE_RD_BYPASS)
    ) u_buffer (
        .clk         (clk),
        .rst         (rst),
        .rd_valid    (rd_valid),
        .rd_hdr      (rd_hdr),
        .wr_valid    (wr_valid),
        .wr_req      (wr_req),
        .rd_alm_full (rd_alm_full),
        .wr_alm_full (wr_alm_full),
        .tx          (tx_if)
    );

    mpf_req_arbiter u_arbiter (
        .tx  (tx_if),
        .mem (mem_if)
    );

    mpf_mem_port u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem          (mem_if),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_tag   (rd_rsp_tag),
        .rd_rsp_data  (rd_rsp_data),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_tag   (wr_ack_tag)
    );

endmodule

`default_nettype wire

/* mpf_mem_port.sv */
// On-chip memory with registered responses
`timescale 1ns/10ps
`default_nettype none

module mpf_mem_port (
    input  wire                             clk,
    input  wire                             rst,

    // Request strobe from the arbiter
    mpf_mem_if.mem                          mem,

    // Read response, no flow control
    output logic                            rd_rsp_valid,
    output logic [mpf_pkg::MPF_TAG_W-1:0]   rd_rsp_tag,
    output logic [mpf_pkg::MPF_DATA_W-1:0]  rd_rsp_data,

    // Write acknowledgement
    output logic                            wr_ack_valid,
    output logic [mpf_pkg::MPF_TAG_W-1:0]   wr_ack_tag
);

    localparam int DEPTH = 2 ** mpf_pkg::MPF_ADDR_W;

    // Contents are undefined until written
    logic [mpf_pkg::MPF_DATA_W-1:0] ram [DEPTH];

    // ==========================================================
    // Array and payload
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (mem.req_valid && mem.req_write)
            ram[mem.req_addr] <= mem.req_data;
    end

    // Read data is the array word sampled at the request edge, so it
    // never reflects a write issued in the following cycle
    always_ff @(posedge clk)
    begin
        rd_rsp_data <= ram[mem.req_addr];
        rd_rsp_tag  <= mem.req_tag;
        wr_ack_tag  <= mem.req_tag;
    end

    // ==========================================================
    // Response valids
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_rsp_valid <= 1'b0;
            wr_ack_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= mem.req_valid && !mem.req_write;
            wr_ack_valid <= mem.req_valid && mem.req_write;
        end
    end

    // A request strobe always carries a resolved address and tag
    a_req_known: assert property (@(posedge clk) disable iff (rst)
        mem.req_valid |-> !$isunknown({mem.req_addr, mem.req_tag}));

endmodule

`default_nettype wire

/* mpf_req_arbiter.sv */
// Read and write request arbiter
`timescale 1ns/10ps
`default_nettype none

module mpf_req_arbiter (
    // Buffered request heads and their dequeue strobes
    mpf_tx_if.arb_side tx,

    // Single merged request toward the memory
    mpf_mem_if.arb     mem
);

    // ==========================================================
    // Selection
    // ==========================================================

    // Writes always win. A read therefore never overtakes a write that
    // was accepted before it, which gives the read-after-write ordering
    logic pick_wr;
    logic pick_rd;

    always_comb
    begin
        pick_wr = tx.wr_valid;
        pick_rd = tx.rd_valid && !tx.wr_valid;
    end

    // Dequeue and the memory request happen in the same cycle
    always_comb
    begin
        tx.wr_deq = pick_wr;
        tx.rd_deq = pick_rd;
    end

    // ==========================================================
    // Memory request
    // ==========================================================

    always_comb
    begin
        mem.req_valid = pick_wr || pick_rd;
        mem.req_write = pick_wr;

        // Header fields come from whichever channel won
        if (pick_wr)
        begin
            mem.req_addr = tx.wr_req.hdr.addr;
            mem.req_tag  = tx.wr_req.hdr.tag;
        end
        else
        begin
            mem.req_addr = tx.rd_hdr.addr;
            mem.req_tag  = tx.rd_hdr.tag;
        end

        // Data is only meaningful for writes, so it is passed through unmuxed
        mem.req_data = tx.wr_req.data;
    end

endmodule

`default_nettype wire

/* mpf_afu_buffer.sv */
// Accelerator-side request buffer
`timescale 1ns/10ps
`default_nettype none

module mpf_afu_buffer #(
    parameter int N_ENTRIES        = 8,
    parameter int THRESHOLD        = 4,
    parameter int ENABLE_RD_BYPASS = 1
) (
    input  wire              clk,
    input  wire              rst,

    // Raw requests straight from the accelerator
    input  wire              rd_valid,
    input  wire mpf_pkg::t_rd_hdr rd_hdr,
    input  wire              wr_valid,
    input  wire mpf_pkg::t_wr_req wr_req,

    // Flow control back to the accelerator
    output logic             rd_alm_full,
    output logic             wr_alm_full,

    // Buffered side toward the arbiter
    mpf_tx_if.buf_side       tx
);

    localparam int RD_BITS = $bits(mpf_pkg::t_rd_hdr);
    localparam int WR_BITS = $bits(mpf_pkg::t_wr_req);

    // ==========================================================
    // Channel 0, read requests
    // ==========================================================

    mpf_pkg::t_rd_hdr rd_first;
    logic             rd_not_empty;
    logic             rd_enq;
    logic             rd_fifo_deq;

    generate
        if (ENABLE_RD_BYPASS != 0)
        begin : g_rd_bypass
            // An empty FIFO lets the incoming read go straight through
            assign tx.rd_valid = rd_not_empty || rd_valid;
            assign tx.rd_hdr   = rd_not_empty ? rd_first : rd_hdr;

            // Store the read unless the arbiter took it directly this cycle
            assign rd_enq = rd_valid && (rd_not_empty || !tx.rd_deq);

            // A dequeue of a bypassed read must not touch the FIFO
            assign rd_fifo_deq = tx.rd_deq && rd_not_empty;
        end
        else
        begin : g_rd_fifo_only
            // Every read passes through the FIFO and costs one extra cycle
            assign tx.rd_valid  = rd_not_empty;
            assign tx.rd_hdr    = rd_first;
            assign rd_enq       = rd_valid;
            assign rd_fifo_deq  = tx.rd_deq;
        end
    endgenerate

    mpf_fifo_lutram #(
        .N_DATA_BITS (RD_BITS),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    ) u_rd_fifo (
        .clk         (clk),
        .rst         (rst),
        .enq_data    (rd_hdr),
        .enq_en      (rd_enq),
        .almost_full (rd_alm_full),
        .first       (rd_first),
        .deq_en      (rd_fifo_deq),
        .not_empty   (rd_not_empty)
    );

    // ==========================================================
    // Channel 1, write requests
    // ==========================================================

    // No bypass on the wide write path
    mpf_pkg::t_wr_req wr_first;
    logic             wr_not_empty;

    assign tx.wr_valid = wr_not_empty;
    assign tx.wr_req   = wr_first;

    mpf_fifo_lutram #(
        .N_DATA_BITS (WR_BITS),
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    ) u_wr_fifo (
        .clk         (clk),
        .rst         (rst),
        .enq_data    (wr_req),
        .enq_en      (wr_valid),
        .almost_full (wr_alm_full),
        .first       (wr_first),
        .deq_en      (tx.wr_deq),
        .not_empty   (wr_not_empty)
    );

    // The arbiter only consumes a head that is actually presented
    a_rd_deq_valid: assert property (@(posedge clk) disable iff (rst)
        tx.rd_deq |-> tx.rd_valid);
    a_wr_deq_valid: assert property (@(posedge clk) disable iff (rst)
        tx.wr_deq |-> tx.wr_valid);

endmodule

`default_nettype wire

/* mpf_fifo_lutram.sv */
// Register-array request FIFO
`timescale 1ns/10ps
`default_nettype none

module mpf_fifo_lutram #(
    parameter int N_DATA_BITS = 14,
    parameter int N_ENTRIES   = 8,
    parameter int THRESHOLD   = 4
) (
    input  wire                    clk,
    input  wire                    rst,

    input  wire  [N_DATA_BITS-1:0] enq_data,
    input  wire                    enq_en,
    output logic                   almost_full,

    // Head of the queue, meaningful only while not_empty is high
    output logic [N_DATA_BITS-1:0] first,
    input  wire                    deq_en,
    output logic                   not_empty
);

    localparam int PTR_W = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_W = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] data_q [N_ENTRIES];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    // Pointers wrap explicitly so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(N_ENTRIES - 1))
            return '0;
        else
            return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (enq_en)
            data_q[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= ptr_next(wr_ptr);
            if (deq_en)
                rd_ptr <= ptr_next(rd_ptr);

            // Simultaneous enqueue and dequeue leave the occupancy unchanged
            case ({enq_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A newly written entry shows up here one cycle after its enqueue
    assign first     = data_q[rd_ptr];
    assign not_empty = (count != '0);

    // Almost-full comes only from registered state, so the upstream
    // flow control has no combinational path through this FIFO
    assign almost_full = (N_ENTRIES - int'(count)) <= THRESHOLD;

    // The producer must respect almost_full and never overrun the array
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        enq_en |-> (count != CNT_W'(N_ENTRIES)));

    // The consumer only pulls an entry that is really there
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        deq_en |-> not_empty);

endmodule

`default_nettype wire

/* mpf_ifs.sv */
// Memory shim internal interfaces
`timescale 1ns/10ps
`default_nettype none

// Buffered requests travel from the input buffer to the arbiter
// A request stays at the head until its dequeue strobe fires
interface mpf_tx_if;
    logic               rd_valid;
    mpf_pkg::t_rd_hdr   rd_hdr;
    logic               wr_valid;
    mpf_pkg::t_wr_req   wr_req;
    logic               rd_deq;
    logic               wr_deq;

    // Buffer presents requests and sees the dequeue strobes
    modport buf_side (
        output rd_valid,
        output rd_hdr,
        output wr_valid,
        output wr_req,
        input  rd_deq,
        input  wr_deq
    );

    // Arbiter sees the heads and consumes them
    modport arb_side (
        input  rd_valid,
        input  rd_hdr,
        input  wr_valid,
        input  wr_req,
        output rd_deq,
        output wr_deq
    );
endinterface

// One memory request per cycle with no back-pressure
interface mpf_mem_if;
    logic                            req_valid;
    logic                            req_write;
    logic [mpf_pkg::MPF_ADDR_W-1:0]  req_addr;
    logic [mpf_pkg::MPF_TAG_W-1:0]   req_tag;
    logic [mpf_pkg::MPF_DATA_W-1:0]  req_data;

    modport arb (output req_valid, output req_write, output req_addr, output req_tag,
                 output req_data);
    modport mem (input req_valid, input req_write, input req_addr, input req_tag,
                 input req_data);
endinterface

`default_nettype wire

/* mpf_pkg.sv */
// Memory shim shared definitions
`default_nettype none

package mpf_pkg;

    // ==========================================================
    // Widths
    // ==========================================================

    // Word address into the on-chip memory, 256 words deep
    localparam int MPF_ADDR_W = 8;

    // Request tag, echoed back unchanged in every response
    localparam int MPF_TAG_W = 6;

    // One data word per request, no multi-beat transfers
    localparam int MPF_DATA_W = 64;

    // ==========================================================
    // Request headers
    // ==========================================================

    // Read request header carried on channel 0
    typedef struct packed {
        logic [MPF_ADDR_W-1:0] addr;
        logic [MPF_TAG_W-1:0]  tag;
    } t_rd_hdr;

    // Write request header carried on channel 1
    typedef struct packed {
        logic [MPF_ADDR_W-1:0] addr;
        logic [MPF_TAG_W-1:0]  tag;
    } t_wr_hdr;

    // Complete write payload as stored in the channel 1 FIFO
    // The data word sits below the header
    typedef struct packed {
        t_wr_hdr               hdr;
        logic [MPF_DATA_W-1:0] data;
    } t_wr_req;

endpackage

`default_nettype wire
